/* flist.f */
+incdir+verilog
verilog/exec_pkg.sv
verilog/register_file.sv
verilog/decode_unit.sv
verilog/alu.sv
verilog/execute_unit.sv
verilog/writeback_unit.sv
verilog/exec_core_top.sv
verification/exec_core_checker.sv
verification/exec_core_tb.sv

/* verification/exec_core_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module exec_core_checker (
    input wire logic                    clock,
    input wire logic                    reset,
    input wire logic                    retire_valid,
    input wire logic                    retire_ready,
    input wire logic [`EXEC_REG_AW-1:0] retire_rd,
    input wire logic [`EXEC_XLEN-1:0]   retire_value,
    input wire logic                    retire_write,
    input wire logic                    wb_enable,
    input wire logic [`EXEC_REG_AW-1:0] wb_addr
);

    int assert_failures = 0;

    // Pipeline must come out of reset empty
    reset_quiet: assert property (@(posedge clock) reset |=> !retire_valid && !wb_enable)
        else begin
            assert_failures++;
            $error("retire_valid or wb_enable high on the first edge after reset");
        end

    retire_hold: assert property (@(posedge clock) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_rd)
            && $stable(retire_value) && $stable(retire_write))
        else begin
            assert_failures++;
            $error("retire payload changed while retire_ready was low");
        end

    no_x0_write: assert property (@(posedge clock) disable iff (reset)
        wb_enable |-> wb_addr != '0)
        else begin
            assert_failures++;
            $error("register file write to x0");
        end

endmodule

`default_nettype wire

/* verification/exec_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module exec_core_tb;

    localparam int MAX_ENTRIES    = 64;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int GROUPS         = 4;

    logic                    clock = 1'b0;
    logic                    reset;
    logic                    in_valid;
    logic                    in_ready;
    logic [`EXEC_XLEN-1:0]   instr;
    logic [`EXEC_XLEN-1:0]   pc;
    logic                    retire_valid;
    logic                    retire_ready;
    logic [`EXEC_REG_AW-1:0] retire_rd;
    logic [`EXEC_XLEN-1:0]   retire_value;
    logic                    retire_write;

    logic [31:0] trace_mem [0:5*MAX_ENTRIES-1]; // instr, pc, rd, value, write
    integer      seed = 32'h9bd3;
    int          entry_count;
    int          accepted_count;
    int          retired_count;
    int          stall_cycles;
    int          check_count;
    int          error_count;
    int          reset_errors;
    int          extra_retires;
    int          group_errors [GROUPS];
    int          group_entries [GROUPS];
    bit          timed_out;

    always #10 clock = ~clock;

    exec_core_top dut_i (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .instr        (instr),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .retire_write (retire_write)
    );

    bind exec_core_top exec_core_checker checker_i (
        .clock        (clock),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .retire_write (retire_write),
        .wb_enable    (wb_enable),
        .wb_addr      (wb_addr)
    );

    // Trace layout 0-9 immediate, 10-19 register, 20-25 chain, 26-29 x0
    function automatic int group_of(input int idx);
        if (idx < 10) return 0;
        else if (idx < 20) return 1;
        else if (idx < 26) return 2;
        else return 3;
    endfunction

    function automatic int last_entry_of(input int g);
        case (g)
            0: return 9;
            1: return 19;
            2: return 25;
            default: return 29;
        endcase
    endfunction

    function automatic string title_of(input int g);
        case (g)
            0: return "register-immediate, LUI and AUIPC";
            1: return "register-register";
            2: return "back-to-back dependencies";
            default: return "x0 rule";
        endcase
    endfunction

    always @(negedge clock) begin
        if (!reset) begin
            retire_ready = ($unsigned($random(seed)) % 100) < 70; // About 70 percent
        end
    end

    // Retirement monitor
    always @(posedge clock) begin
        int          idx;
        int          g;
        logic [31:0] exp_rd;
        logic [31:0] exp_value;
        logic [31:0] exp_write;
        if (!reset) begin
            if (retire_valid && accepted_count == 0) begin
                $display("Retirement at %0t before any instruction was accepted", $time);
                error_count++;
                reset_errors++;
            end
            if (in_valid && in_ready) begin
                if (accepted_count == 0) begin
                    $display("reset state: %0d errors", reset_errors);
                end
                accepted_count++;
            end
            if (retire_valid && !retire_ready) stall_cycles++;
            if (retire_valid && retire_ready && retired_count >= entry_count) begin
                $display("Retirement at %0t with no trace entry left", $time);
                error_count++;
                extra_retires++;
            end else if (retire_valid && retire_ready) begin
                idx       = retired_count;
                g         = group_of(idx);
                exp_rd    = trace_mem[5*idx+2];
                exp_value = trace_mem[5*idx+3];
                exp_write = trace_mem[5*idx+4];
                check_count += 3;
                group_entries[g]++;
                if (retire_rd !== exp_rd[`EXEC_REG_AW-1:0]) begin
                    $display("FAILED time %0t: retire_rd expected %0d got %0d",
                             $time, exp_rd, retire_rd);
                    error_count++;
                    group_errors[g]++;
                end
                if (retire_value !== exp_value) begin
                    $display("FAILED time %0t: retire_value expected %h got %h",
                             $time, exp_value, retire_value);
                    error_count++;
                    group_errors[g]++;
                end
                if (retire_write !== exp_write[0]) begin
                    $display("FAILED time %0t: retire_write expected %b got %b",
                             $time, exp_write[0], retire_write);
                    error_count++;
                    group_errors[g]++;
                end
                retired_count++;
                if (idx == last_entry_of(g)) begin
                    $display("%s: %0d entries, %0d errors",
                             title_of(g), group_entries[g], group_errors[g]);
                end
            end
        end
    end

    initial begin
        bit accepted;
        int waited;
        reset        = 1'b1;
        in_valid     = 1'b0;
        instr        = '0;
        pc           = '0;
        retire_ready = 1'b0;
        timed_out    = 1'b0;
        $readmemh("verification/exec_core_trace.txt", trace_mem);
        while (entry_count < MAX_ENTRIES && !$isunknown(trace_mem[5*entry_count])) begin
            entry_count++;
        end
        if (entry_count == 0) begin
            $display("The trace file gave no entries");
            error_count++;
        end

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_count += 2;
        if (in_ready !== 1'b1) begin
            $display("FAILED time %0t: in_ready expected 1 got %b", $time, in_ready);
            error_count++;
            reset_errors++;
        end
        if (retire_valid !== 1'b0) begin
            $display("FAILED time %0t: retire_valid expected 0 got %b", $time, retire_valid);
            error_count++;
            reset_errors++;
        end

        for (int i = 0; i < entry_count && !timed_out; i++) begin
            @(negedge clock);
            in_valid = 1'b1;
            instr    = trace_mem[5*i];
            pc       = trace_mem[5*i+1];
            accepted = 1'b0;
            waited   = 0;
            while (!accepted && !timed_out) begin
                @(posedge clock);
                if (in_ready) begin
                    accepted = 1'b1;
                end else begin
                    waited++;
                    if (waited >= TIMEOUT_CYCLES) begin
                        $display("Timeout: entry %0d not accepted within %0d cycles",
                                 i, TIMEOUT_CYCLES);
                        timed_out = 1'b1;
                    end
                end
            end
        end
        @(negedge clock);
        in_valid = 1'b0;

        waited = 0;
        while (!timed_out && retired_count < entry_count) begin
            @(negedge clock);
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                $display("Timeout: only %0d of %0d entries retired", retired_count, entry_count);
                timed_out = 1'b1;
            end
        end
        repeat (10) @(negedge clock); // Window for duplicate retirements

        check_count++;
        if (dut_i.checker_i.assert_failures != 0) begin
            $display("Checker assertions failed %0d times", dut_i.checker_i.assert_failures);
            error_count++;
        end
        check_count++;
        if (retired_count != entry_count) begin
            $display("Lost retirements: %0d of %0d entries retired", retired_count, entry_count);
            error_count++;
        end
        $display("back-pressure: %0d of %0d retired, %0d stall cycles, %0d extra",
                 retired_count, entry_count, stall_cycles, extra_retires);
        $display("Totals: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/exec_core_trace.txt */
// instr    pc       rd value    write   (hex, one retirement per line, in order)
// entries 0-9 immediate, 10-19 register-register, 20-25 dependency chain, 26-29 x0
00500093 00000000 01 00000005 1
FFD00113 00000004 02 FFFFFFFD 1
00112193 00000008 03 00000001 1
00113213 0000000C 04 00000000 1
0F00C293 00000010 05 000000F5 1
7F00E313 00000014 06 000007F5 1
0FF17393 00000018 07 000000FD 1
12345437 0000001C 08 12345000 1
00001497 00000020 09 00001020 1
67840513 00000024 0A 12345678 1
002085B3 00000028 0B 00000002 1
40208633 0000002C 0C 00000008 1
001516B3 00000030 0D 468ACF00 1
00112733 00000034 0E 00000001 1
001137B3 00000038 0F 00000000 1
00254833 0000003C 10 EDCBA985 1
001158B3 00000040 11 07FFFFFF 1
40115933 00000044 12 FFFFFFFF 1
0062E9B3 00000048 13 000007F5 1
00757A33 0000004C 14 00000078 1
06400A93 00000050 15 00000064 1
001A8A93 00000054 15 00000065 1
015A8B33 00000058 16 000000CA 1
415B0BB3 0000005C 17 00000065 1
004B9C13 00000060 18 00000650 1
401C5C93 00000064 19 00000328 1
00708013 00000068 00 0000000C 0
00100D33 0000006C 1A 00000005 1
ABCDE037 00000070 00 ABCDE000 0
00006DB3 00000074 1B 00000000 1

/* verilog/alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module alu (
    input  wire logic [`EXEC_XLEN-1:0]  a,
    input  wire logic [`EXEC_XLEN-1:0]  b,
    input  wire exec_pkg::alu_op_e      op,
    output logic      [`EXEC_XLEN-1:0]  result
);

    import exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt); // Keeps sign bit
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module decode_unit (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      in_valid,
    output logic                           in_ready,
    input  wire logic [`EXEC_XLEN-1:0]     instr,
    input  wire logic [`EXEC_XLEN-1:0]     pc,
    output logic      [`EXEC_REG_AW-1:0]   rs1_addr,
    output logic      [`EXEC_REG_AW-1:0]   rs2_addr,
    input  wire logic [`EXEC_XLEN-1:0]     rs1_data,
    input  wire logic [`EXEC_XLEN-1:0]     rs2_data,
    input  wire logic                      wb_enable,
    input  wire logic [`EXEC_REG_AW-1:0]   wb_addr,
    output logic                           dec_valid,
    input  wire logic                      dec_ready,
    output logic      [`EXEC_XLEN-1:0]     dec_pc,
    output logic      [`EXEC_REG_AW-1:0]   dec_rd,
    output logic                           dec_write,
    output exec_pkg::alu_op_e              dec_alu_op,
    output exec_pkg::imm_kind_e            dec_imm_kind,
    output logic      [`EXEC_XLEN-1:0]     dec_imm,
    output exec_pkg::src1_sel_e            dec_src1_sel,
    output exec_pkg::src2_sel_e            dec_src2_sel,
    output logic                           dec_invert,
    output logic      [`EXEC_XLEN-1:0]     dec_rs1_value,
    output logic      [`EXEC_XLEN-1:0]     dec_rs2_value
);

    import exec_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic                       funct7_alt;
    logic [`EXEC_REG_AW-1:0]    rd;
    alu_op_e                    alu_op_d;
    imm_kind_e                  imm_kind_d;
    logic [`EXEC_XLEN-1:0]      imm_d;
    src1_sel_e                  src1_d;
    src2_sel_e                  src2_d;
    logic                       write_d;
    logic                       invert_d;
    logic                       uses_rs1;
    logic                       uses_rs2;
    logic [`EXEC_REG_COUNT-1:0] pending;
    logic [`EXEC_REG_COUNT-1:0] pending_next;
    logic                       hazard;
    logic                       accept;

    assign opcode     = instr[6:0];
    assign rd         = instr[11:7];
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];
    assign rs1_addr   = instr[19:15];
    assign rs2_addr   = instr[24:20];

    always_comb begin
        imm_kind_d = IMM_NONE;
        imm_d      = '0;
        src1_d     = SRC1_REG;
        src2_d     = SRC2_REG;
        write_d    = 1'b1;
        invert_d   = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        case (funct3)
            3'b000: alu_op_d = (opcode == OPC_OP && funct7_alt) ? ALU_SUB : ALU_ADD;
            3'b001: alu_op_d = ALU_SLL;
            3'b010: alu_op_d = ALU_SLT;
            3'b011: alu_op_d = ALU_SLTU;
            3'b100: alu_op_d = ALU_XOR;
            3'b101: alu_op_d = funct7_alt ? ALU_SRA : ALU_SRL; // SRAI too
            3'b110: alu_op_d = ALU_OR;
            default: alu_op_d = ALU_AND;
        endcase
        case (opcode)
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                src2_d   = SRC2_IMM;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_kind_d = IMM_SHAMT;
                    imm_d      = {{(`EXEC_XLEN-5){1'b0}}, instr[24:20]};
                end else begin
                    imm_kind_d = IMM_I12;
                    imm_d      = {{(`EXEC_XLEN-12){1'b0}}, instr[31:20]};
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                alu_op_d   = ALU_ADD;
                imm_kind_d = IMM_U20;
                imm_d      = {{(`EXEC_XLEN-20){1'b0}}, instr[31:12]};
                src1_d     = (opcode == OPC_LUI) ? SRC1_ZERO : SRC1_PC;
                src2_d     = SRC2_IMM;
            end
            default: write_d = 1'b0;
        endcase
    end

    // Destination checked too so an older write cannot clear a newer pending bit
    assign hazard = (uses_rs1 && pending[rs1_addr]) || (uses_rs2 && pending[rs2_addr])
                  || (write_d && pending[rd]);
    assign in_ready = (!dec_valid || dec_ready) && !hazard;
    assign accept   = in_valid && in_ready;

    always_comb begin
        pending_next = pending;
        if (wb_enable) begin
            pending_next[wb_addr] = 1'b0;
        end
        if (accept && write_d && rd != '0) begin // Set wins over same-edge clear
            pending_next[rd] = 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending   <= '0;
            dec_valid <= 1'b0;
        end else begin
            pending <= pending_next;
            if (!dec_valid || dec_ready) begin
                dec_valid <= accept; // Bubble while stalled
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            dec_pc        <= pc;
            dec_rd        <= rd;
            dec_write     <= write_d;
            dec_alu_op    <= alu_op_d;
            dec_imm_kind  <= imm_kind_d;
            dec_imm       <= imm_d;
            dec_src1_sel  <= src1_d;
            dec_src2_sel  <= src2_d;
            dec_invert    <= invert_d;
            dec_rs1_value <= rs1_data;
            dec_rs2_value <= rs2_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Data path and pc width
`define EXEC_XLEN 32

// Architectural integer registers
`define EXEC_REG_COUNT 32
`define EXEC_REG_AW ($clog2(`EXEC_REG_COUNT))

`endif

/* verilog/exec_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module exec_core_top (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      in_valid,
    output logic                           in_ready,
    input  wire logic [`EXEC_XLEN-1:0]     instr,
    input  wire logic [`EXEC_XLEN-1:0]     pc,
    output logic                           retire_valid,
    input  wire logic                      retire_ready,
    output logic      [`EXEC_REG_AW-1:0]   retire_rd,
    output logic      [`EXEC_XLEN-1:0]     retire_value,
    output logic                           retire_write
);

    import exec_pkg::*;

    logic [`EXEC_REG_AW-1:0] rs1_addr;
    logic [`EXEC_REG_AW-1:0] rs2_addr;
    logic [`EXEC_XLEN-1:0]   rs1_data;
    logic [`EXEC_XLEN-1:0]   rs2_data;
    logic                    wb_enable;
    logic [`EXEC_REG_AW-1:0] wb_addr;
    logic [`EXEC_XLEN-1:0]   wb_data;

    logic                    dec_valid;
    logic                    dec_ready;
    logic [`EXEC_XLEN-1:0]   dec_pc;
    logic [`EXEC_REG_AW-1:0] dec_rd;
    logic                    dec_write;
    alu_op_e                 dec_alu_op;
    imm_kind_e               dec_imm_kind;
    logic [`EXEC_XLEN-1:0]   dec_imm;
    src1_sel_e               dec_src1_sel;
    src2_sel_e               dec_src2_sel;
    logic                    dec_invert;
    logic [`EXEC_XLEN-1:0]   dec_rs1_value;
    logic [`EXEC_XLEN-1:0]   dec_rs2_value;

    logic                    ex_valid;
    logic                    ex_ready;
    logic [`EXEC_REG_AW-1:0] ex_rd;
    logic                    ex_write;
    logic [`EXEC_XLEN-1:0]   ex_result;

    register_file register_file_i (
        .clock     (clock),
        .reset     (reset),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_enable (wb_enable),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    decode_unit decode_unit_i (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .instr         (instr),
        .pc            (pc),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb_enable     (wb_enable),
        .wb_addr       (wb_addr),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_pc        (dec_pc),
        .dec_rd        (dec_rd),
        .dec_write     (dec_write),
        .dec_alu_op    (dec_alu_op),
        .dec_imm_kind  (dec_imm_kind),
        .dec_imm       (dec_imm),
        .dec_src1_sel  (dec_src1_sel),
        .dec_src2_sel  (dec_src2_sel),
        .dec_invert    (dec_invert),
        .dec_rs1_value (dec_rs1_value),
        .dec_rs2_value (dec_rs2_value)
    );

    execute_unit execute_unit_i (
        .clock         (clock),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_pc        (dec_pc),
        .dec_rd        (dec_rd),
        .dec_write     (dec_write),
        .dec_alu_op    (dec_alu_op),
        .dec_imm_kind  (dec_imm_kind),
        .dec_imm       (dec_imm),
        .dec_src1_sel  (dec_src1_sel),
        .dec_src2_sel  (dec_src2_sel),
        .dec_invert    (dec_invert),
        .dec_rs1_value (dec_rs1_value),
        .dec_rs2_value (dec_rs2_value),
        .ex_valid      (ex_valid),
        .ex_ready      (ex_ready),
        .ex_rd         (ex_rd),
        .ex_write      (ex_write),
        .ex_result     (ex_result)
    );

    writeback_unit writeback_unit_i (
        .clock        (clock),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_ready     (ex_ready),
        .ex_rd        (ex_rd),
        .ex_write     (ex_write),
        .ex_result    (ex_result),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .retire_write (retire_write),
        .wb_enable    (wb_enable),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // How the raw immediate is widened in execute
    typedef enum logic [1:0] {
        IMM_NONE  = 2'd0,
        IMM_I12   = 2'd1, // Sign extended
        IMM_U20   = 2'd2, // Upper 20 bits, low 12 zero
        IMM_SHAMT = 2'd3  // Zero extended 5 bits
    } imm_kind_e;

    typedef enum logic [1:0] {
        SRC1_REG  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_IMM  = 2'd0,
        SRC2_REG  = 2'd1,
        SRC2_ZERO = 2'd2
    } src2_sel_e;

endpackage

`default_nettype wire

/* verilog/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module execute_unit (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      dec_valid,
    output logic                           dec_ready,
    input  wire logic [`EXEC_XLEN-1:0]     dec_pc,
    input  wire logic [`EXEC_REG_AW-1:0]   dec_rd,
    input  wire logic                      dec_write,
    input  wire exec_pkg::alu_op_e         dec_alu_op,
    input  wire exec_pkg::imm_kind_e       dec_imm_kind,
    input  wire logic [`EXEC_XLEN-1:0]     dec_imm,
    input  wire exec_pkg::src1_sel_e       dec_src1_sel,
    input  wire exec_pkg::src2_sel_e       dec_src2_sel,
    input  wire logic                      dec_invert,
    input  wire logic [`EXEC_XLEN-1:0]     dec_rs1_value,
    input  wire logic [`EXEC_XLEN-1:0]     dec_rs2_value,
    output logic                           ex_valid,
    input  wire logic                      ex_ready,
    output logic      [`EXEC_REG_AW-1:0]   ex_rd,
    output logic                           ex_write,
    output logic      [`EXEC_XLEN-1:0]     ex_result
);

    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] imm_full;
    logic [`EXEC_XLEN-1:0] operand_a;
    logic [`EXEC_XLEN-1:0] operand_b;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] result;
    logic                  transfer;

    always_comb begin
        case (dec_imm_kind)
            IMM_I12:   imm_full = {{(`EXEC_XLEN-12){dec_imm[11]}}, dec_imm[11:0]};
            IMM_U20:   imm_full = {dec_imm[19:0], 12'd0};
            IMM_SHAMT: imm_full = {{(`EXEC_XLEN-5){1'b0}}, dec_imm[4:0]};
            default:   imm_full = '0;
        endcase
    end

    always_comb begin
        case (dec_src1_sel)
            SRC1_REG: operand_a = dec_rs1_value;
            SRC1_PC:  operand_a = dec_pc;
            default:  operand_a = '0;
        endcase
    end

    always_comb begin
        case (dec_src2_sel)
            SRC2_IMM: operand_b = imm_full;
            SRC2_REG: operand_b = dec_rs2_value;
            default:  operand_b = '0;
        endcase
    end

    alu alu_i (
        .a      (operand_a),
        .b      (operand_b),
        .op     (dec_alu_op),
        .result (alu_result)
    );

    // Invert only touches the compare bit
    assign result = alu_result ^ {{(`EXEC_XLEN-1){1'b0}}, dec_invert};

    assign dec_ready = !ex_valid || ex_ready;
    assign transfer  = dec_valid && dec_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (dec_ready) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (transfer) begin
            ex_rd     <= dec_rd;
            ex_write  <= dec_write;
            ex_result <= result;
        end
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module register_file (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic [`EXEC_REG_AW-1:0]     rs1_addr,
    input  wire logic [`EXEC_REG_AW-1:0]     rs2_addr,
    output logic      [`EXEC_XLEN-1:0]       rs1_data,
    output logic      [`EXEC_XLEN-1:0]       rs2_data,
    input  wire logic                        wb_enable,
    input  wire logic [`EXEC_REG_AW-1:0]     wb_addr,
    input  wire logic [`EXEC_XLEN-1:0]       wb_data
);

    logic [`EXEC_XLEN-1:0] regs [`EXEC_REG_COUNT];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable && wb_addr != '0) begin // x0 stays zero
            regs[wb_addr] <= wb_data;
        end
    end

    // No bypass so decode waits a cycle after the write
    always_comb begin
        rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
        rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    end

endmodule

`default_nettype wire

/* verilog/writeback_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_config.svh"

module writeback_unit (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      ex_valid,
    output logic                           ex_ready,
    input  wire logic [`EXEC_REG_AW-1:0]   ex_rd,
    input  wire logic                      ex_write,
    input  wire logic [`EXEC_XLEN-1:0]     ex_result,
    output logic                           retire_valid,
    input  wire logic                      retire_ready,
    output logic      [`EXEC_REG_AW-1:0]   retire_rd,
    output logic      [`EXEC_XLEN-1:0]     retire_value,
    output logic                           retire_write,
    output logic                           wb_enable,
    output logic      [`EXEC_REG_AW-1:0]   wb_addr,
    output logic      [`EXEC_XLEN-1:0]     wb_data
);

    assign ex_ready = !retire_valid || retire_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else if (ex_ready) begin
            retire_valid <= ex_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (ex_valid && ex_ready) begin
            retire_rd    <= ex_rd;
            retire_value <= ex_result; // Shown even for x0
            retire_write <= ex_write && ex_rd != '0;
        end
    end

    // Register file write only in the accepting cycle
    assign wb_enable = retire_valid && retire_ready && retire_write;
    assign wb_addr   = retire_rd;
    assign wb_data   = retire_value;

endmodule

`default_nettype wire
